//--- hdl/stream_params.svh
/*
  Stream pipeline parameters
  Fixed beat widths and the register slice counts on either side
  of the framing checker
*/

`ifndef STREAM_PARAMS_SVH
`define STREAM_PARAMS_SVH

// Data bytes carried in one beat
`define STREAM_DAT_BYTS 8

// Width of the sideband control field, passed through untouched
`define STREAM_CTL_BITS 8

// Register slices in front of the checker and behind it
`define STREAM_IN_STAGES 2
`define STREAM_OUT_STAGES 1

`endif

//--- hdl/stream_pkg.sv
/*
  Stream pipeline types
  Width typedefs and the packed beat struct that every link
  of the pipeline carries alongside its valid and ready signals
*/

`include "stream_params.svh"

package stream_pkg;

  // Beat payload, one byte per lane
  typedef logic [`STREAM_DAT_BYTS*8-1:0] dat_t;

  // Unused bytes in the last beat of a packet
  // Zero means every byte lane holds valid data
  typedef logic [$clog2(`STREAM_DAT_BYTS)-1:0] mod_t;

  // Sideband control bits
  typedef logic [`STREAM_CTL_BITS-1:0] ctl_t;

  // Packet and error counters wrap around when they overflow
  typedef logic [15:0] cnt_t;

  // One beat of the stream
  // The order puts the payload in the upper bits, as it would sit on a bus
  typedef struct packed {
    dat_t dat;
    logic sop;
    logic eop;
    logic err;
    mod_t mod;
    ctl_t ctl;
  } beat_t;

endpackage

//--- hdl/pipeline_if_single.sv
/*
  Single register slice
  Registers one beat with a skid entry behind the main register, so the
  upstream ready is a flop output and throughput stays at one beat per cycle
*/

`timescale 1ns/1ps

module pipeline_if_single (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  stream_pkg::beat_t i_beat,
  input  logic              i_val,
  output logic              o_rdy,
  output stream_pkg::beat_t o_beat,
  output logic              o_val,
  input  logic              i_rdy
);

  import stream_pkg::*;

  // Main register drives the output and the skid register holds the overflow
  beat_t main_q;
  beat_t skid_q;
  logic  main_val_q;
  logic  skid_val_q;

  // The main register may load when it is empty or being drained
  logic  out_free;
  // A beat is taken from upstream this cycle
  logic  in_xfer;

  assign out_free = i_rdy | ~main_val_q;
  assign in_xfer  = i_val & o_rdy;

  // Valid flags for both entries
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      main_val_q <= 1'b0;
      skid_val_q <= 1'b0;
    end else begin
      if (out_free) begin
        if (skid_val_q) begin
          // The parked beat goes out next
          // Upstream sees ready low in this cycle so nothing new arrives
          main_val_q <= 1'b1;
          skid_val_q <= 1'b0;
        end else begin
          main_val_q <= in_xfer;
        end
      end else if (in_xfer) begin
        // Downstream stalled while a beat was accepted, so park it
        skid_val_q <= 1'b1;
      end
    end
  end

  // Payload registers
  always_ff @(posedge i_clk) begin
    if (out_free) begin
      // The skid entry is older than anything upstream and goes first
      main_q <= skid_val_q ? skid_q : i_beat;
    end
    if (!out_free && in_xfer) begin
      skid_q <= i_beat;
    end
  end

  // Ready comes straight from a flop and only drops once the skid entry is used
  assign o_rdy  = ~skid_val_q;
  assign o_beat = main_q;
  assign o_val  = main_val_q;

endmodule

//--- hdl/pipeline_if.sv
/*
  Register slice chain
  Places NUM_STAGES register slices in series on a beat link,
  or a plain combinational path when NUM_STAGES is zero
*/

`timescale 1ns/1ps

module pipeline_if #(
  parameter int NUM_STAGES = 1
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  stream_pkg::beat_t i_beat,
  input  logic              i_val,
  output logic              o_rdy,
  output stream_pkg::beat_t o_beat,
  output logic              o_val,
  input  logic              i_rdy
);

  import stream_pkg::*;

  generate
    if (NUM_STAGES == 0) begin : g_pass

      // No slices, the link is wired straight through
      assign o_beat = i_beat;
      assign o_val  = i_val;
      assign o_rdy  = i_rdy;

    end else begin : g_chain

      // Index 0 is the chain input and index NUM_STAGES is the chain output
      beat_t                 stage_beat [NUM_STAGES:0];
      logic [NUM_STAGES:0]   stage_val;
      logic [NUM_STAGES:0]   stage_rdy;

      assign stage_beat[0]          = i_beat;
      assign stage_val[0]           = i_val;
      assign stage_rdy[NUM_STAGES]  = i_rdy;

      for (genvar g = 0; g < NUM_STAGES; g++) begin : g_stage
        // Slice g sits between link g and link g+1
        pipeline_if_single u_slice (
          .i_clk   (i_clk),
          .i_rst_n (i_rst_n),
          .i_beat  (stage_beat[g]),
          .i_val   (stage_val[g]),
          .o_rdy   (stage_rdy[g]),
          .o_beat  (stage_beat[g+1]),
          .o_val   (stage_val[g+1]),
          .i_rdy   (stage_rdy[g+1])
        );
      end

      assign o_beat = stage_beat[NUM_STAGES];
      assign o_val  = stage_val[NUM_STAGES];
      // Upstream ready is the registered ready of the first slice
      assign o_rdy  = stage_rdy[0];

    end
  endgenerate

endmodule

//--- hdl/stream_frame_check.sv
/*
  Packet framing checker
  Marks beats that break sop/eop framing or carry a stray mod value
  in their err bit, and counts packets and flagged beats
*/

`timescale 1ns/1ps

module stream_frame_check (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  stream_pkg::beat_t i_beat,
  input  logic              i_val,
  output logic              o_rdy,
  output stream_pkg::beat_t o_beat,
  output logic              o_val,
  input  logic              i_rdy,
  output stream_pkg::cnt_t  o_pkt_cnt,
  output stream_pkg::cnt_t  o_err_cnt
);

  import stream_pkg::*;

  // High between a transferred start beat and its eop beat
  logic  in_pkt_q;

  // One flag per framing rule
  logic  sop_in_pkt;
  logic  no_sop_start;
  logic  bad_mod;

  // A beat leaves the checker this cycle
  logic  out_xfer;

  cnt_t  pkt_cnt_q;
  cnt_t  err_cnt_q;

  // A new sop while a packet is still open
  assign sop_in_pkt   = i_beat.sop & in_pkt_q;
  // A beat that opens a packet without sop
  assign no_sop_start = ~i_beat.sop & ~in_pkt_q;
  // Only the last beat of a packet may leave byte lanes empty
  assign bad_mod      = (i_beat.mod != mod_t'(0)) & ~i_beat.eop;

  // Every field passes through and err picks up any rule violation
  always_comb begin
    o_beat     = i_beat;
    o_beat.err = i_beat.err | sop_in_pkt | no_sop_start | bad_mod;
  end

  // The checker adds no storage on the path
  assign o_val    = i_val;
  assign o_rdy    = i_rdy;
  assign out_xfer = o_val & i_rdy;

  // Framing state
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      in_pkt_q <= 1'b0;
    end else if (out_xfer) begin
      // Any beat leaves the packet open unless it is the last one
      // A bad start is still treated as the start of a packet
      in_pkt_q <= ~i_beat.eop;
    end
  end

  // Counters only move on beats that actually leave
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      pkt_cnt_q <= '0;
      err_cnt_q <= '0;
    end else if (out_xfer) begin
      if (i_beat.eop) begin
        pkt_cnt_q <= pkt_cnt_q + cnt_t'(1);
      end
      // Incoming errors count as well as the ones flagged here
      if (o_beat.err) begin
        err_cnt_q <= err_cnt_q + cnt_t'(1);
      end
    end
  end

  assign o_pkt_cnt = pkt_cnt_q;
  assign o_err_cnt = err_cnt_q;

endmodule

//--- hdl/stream_pipe_top.sv
/*
  Stream packet pipeline
  Input register slices, framing checker and output register slices
  joined on valid/ready beat links
*/

`timescale 1ns/1ps

`include "stream_params.svh"

module stream_pipe_top (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  stream_pkg::beat_t i_beat,
  input  logic              i_val,
  output logic              o_rdy,
  output stream_pkg::beat_t o_beat,
  output logic              o_val,
  input  logic              i_rdy,
  output stream_pkg::cnt_t  o_pkt_cnt,
  output stream_pkg::cnt_t  o_err_cnt
);

  import stream_pkg::*;

  // Link from the input slices into the checker
  beat_t chk_in_beat;
  logic  chk_in_val;
  logic  chk_in_rdy;

  // Link from the checker into the output slices
  beat_t chk_out_beat;
  logic  chk_out_val;
  logic  chk_out_rdy;

  pipeline_if #(
    .NUM_STAGES (`STREAM_IN_STAGES)
  ) u_in_pipe (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_beat  (i_beat),
    .i_val   (i_val),
    .o_rdy   (o_rdy),
    .o_beat  (chk_in_beat),
    .o_val   (chk_in_val),
    .i_rdy   (chk_in_rdy)
  );

  // The checker is combinational on the data path, so its ready
  // comes from the first output slice
  stream_frame_check u_check (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_beat    (chk_in_beat),
    .i_val     (chk_in_val),
    .o_rdy     (chk_in_rdy),
    .o_beat    (chk_out_beat),
    .o_val     (chk_out_val),
    .i_rdy     (chk_out_rdy),
    .o_pkt_cnt (o_pkt_cnt),
    .o_err_cnt (o_err_cnt)
  );

  pipeline_if #(
    .NUM_STAGES (`STREAM_OUT_STAGES)
  ) u_out_pipe (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_beat  (chk_out_beat),
    .i_val   (chk_out_val),
    .o_rdy   (chk_out_rdy),
    .o_beat  (o_beat),
    .o_val   (o_val),
    .i_rdy   (i_rdy)
  );

endmodule

//--- verification/stream_pipe_assert.sv
/*
  Stream pipeline handshake assertions
  Bound to the top level, checks reset behavior of the output valid
  and that beats are held stable while they wait for ready
*/

`timescale 1ns/1ps

module stream_pipe_assert (
  input logic              i_clk,
  input logic              i_rst_n,
  input stream_pkg::beat_t i_beat,
  input logic              i_val,
  input logic              o_rdy,
  input stream_pkg::beat_t o_beat,
  input logic              o_val,
  input logic              i_rdy
);

  // A reset cycle leaves the output valid low at the next edge
  a_val_reset: assert property (@(posedge i_clk) !i_rst_n |=> !o_val)
    else $error("o_val high after a reset cycle");

  // A stalled output beat stays valid and unchanged until it is taken
  a_out_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_val && !i_rdy) |=> (o_val && $stable(o_beat)))
    else $error("o_beat changed or dropped while stalled");

  // Input side rule, the source must obey it for the pipeline to work
  a_in_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_val && !o_rdy) |=> (i_val && $stable(i_beat)))
    else $error("i_beat changed or dropped while stalled");

endmodule

bind stream_pipe_top stream_pipe_assert u_assert (
  .i_clk   (i_clk),
  .i_rst_n (i_rst_n),
  .i_beat  (i_beat),
  .i_val   (i_val),
  .o_rdy   (o_rdy),
  .o_beat  (o_beat),
  .o_val   (o_val),
  .i_rdy   (i_rdy)
);

//--- verification/stream_pipe_tb.sv
/*
  Stream pipeline testbench
  Applies a table of packet beats at full rate and under random stalls,
  checks every output beat against a scoreboard and the final counters
*/

`timescale 1ns/1ps

`include "stream_params.svh"

module stream_pipe_tb;

  import stream_pkg::*;

  localparam int NUM_ROWS   = 17;
  localparam int WAIT_LIMIT = 200;
  // Latency is the sum of the slices on both sides of the checker
  localparam int LATENCY    = `STREAM_IN_STAGES + `STREAM_OUT_STAGES;

  // One table row without data and ctl, which come from the row index
  typedef struct packed {
    logic sop;
    logic eop;
    mod_t mod;
    logic err_in;
    logic err_exp;
  } row_t;

  logic  i_clk;
  logic  i_rst_n;
  beat_t i_beat;
  logic  i_val;
  logic  o_rdy;
  beat_t o_beat;
  logic  o_val;
  logic  i_rdy;
  cnt_t  o_pkt_cnt;
  cnt_t  o_err_cnt;

  row_t  rows [NUM_ROWS];
  beat_t exp_q [$];

  int    cyc;
  int    checks;
  int    errors;
  int    timeouts;
  int    out_n;
  int    first_in_cyc;
  int    last_out_cyc;
  bit    stall_mode;

  stream_pipe_top dut_i (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_beat    (i_beat),
    .i_val     (i_val),
    .o_rdy     (o_rdy),
    .o_beat    (o_beat),
    .o_val     (o_val),
    .i_rdy     (i_rdy),
    .o_pkt_cnt (o_pkt_cnt),
    .o_err_cnt (o_err_cnt)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  // Downstream ready is low in about 3 cycles of 10 while stalls are on
  // The next value is drawn at the edge and driven just after it
  initial begin
    logic rdy_next;
    i_rdy = 1'b0;
    forever begin
      @(posedge i_clk);
      rdy_next = stall_mode ? (($urandom % 10) >= 3) : 1'b1;
      #1;
      i_rdy = rdy_next;
    end
  end

  function automatic row_t make_row(input logic sop, input logic eop, input int mod,
                                    input logic err_in, input logic err_exp);
    row_t r;
    r.sop     = sop;
    r.eop     = eop;
    r.mod     = mod_t'(mod);
    r.err_in  = err_in;
    r.err_exp = err_exp;
    return r;
  endfunction

  // Expected err follows the framing rules by hand
  task automatic load_table();
    // Packets of one, two and five beats with mod on the last beat
    rows[0]  = make_row(1'b1, 1'b1, 3, 1'b0, 1'b0);
    rows[1]  = make_row(1'b1, 1'b0, 0, 1'b0, 1'b0);
    rows[2]  = make_row(1'b0, 1'b1, 5, 1'b0, 1'b0);
    rows[3]  = make_row(1'b1, 1'b0, 0, 1'b0, 1'b0);
    rows[4]  = make_row(1'b0, 1'b0, 0, 1'b0, 1'b0);
    rows[5]  = make_row(1'b0, 1'b0, 0, 1'b0, 1'b0);
    rows[6]  = make_row(1'b0, 1'b0, 0, 1'b0, 1'b0);
    rows[7]  = make_row(1'b0, 1'b1, 0, 1'b0, 1'b0);
    // A sop inside an open packet also closes as a one beat packet
    rows[8]  = make_row(1'b1, 1'b0, 0, 1'b0, 1'b0);
    rows[9]  = make_row(1'b1, 1'b1, 1, 1'b0, 1'b1);
    // A beat without sop outside a packet and then a clean end
    rows[10] = make_row(1'b0, 1'b0, 0, 1'b0, 1'b1);
    rows[11] = make_row(1'b0, 1'b1, 2, 1'b0, 1'b0);
    // Nonzero mod without eop
    rows[12] = make_row(1'b1, 1'b0, 4, 1'b0, 1'b1);
    rows[13] = make_row(1'b0, 1'b1, 0, 1'b0, 1'b0);
    // Incoming err on well-formed beats is passed on
    rows[14] = make_row(1'b1, 1'b1, 0, 1'b1, 1'b1);
    rows[15] = make_row(1'b1, 1'b0, 0, 1'b0, 1'b0);
    rows[16] = make_row(1'b0, 1'b1, 7, 1'b1, 1'b1);
  endtask

  function automatic beat_t make_beat(input int r);
    beat_t b;
    b.dat = {8{8'(r)}} ^ 64'h0123_4567_89ab_cdef;
    b.sop = rows[r].sop;
    b.eop = rows[r].eop;
    b.err = rows[r].err_in;
    b.mod = rows[r].mod;
    b.ctl = ctl_t'(8'(r) * 8'd5 + 8'd1);
    return b;
  endfunction

  task automatic compare_beat(input beat_t got, input beat_t exp, input int idx);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: beat %0d got dat=%h sop=%b eop=%b err=%b mod=%0d ctl=%h, %s%h",
               $time, idx, got.dat, got.sop, got.eop, got.err, got.mod, got.ctl,
               "expected ", exp);
    end
  endtask

  task automatic compare_cnt(input cnt_t got, input cnt_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Output monitor and scoreboard sample the outputs at the clock edge
  always @(posedge i_clk) begin
    cyc <= cyc + 1;
    if (i_rst_n && o_val && i_rdy) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERR %0t: output beat with no beat expected", $time);
      end else begin
        compare_beat(o_beat, exp_q.pop_front(), out_n);
      end
      // At full rate the first beat has a fixed latency and no gaps follow
      if (!stall_mode && out_n == 0 && cyc - first_in_cyc != LATENCY) begin
        errors++;
        $display("ERR %0t: first beat latency %0d cycles, expected %0d",
                 $time, cyc - first_in_cyc, LATENCY);
      end
      if (!stall_mode && out_n > 0 && cyc != last_out_cyc + 1) begin
        errors++;
        $display("ERR %0t: gap of %0d cycles between output beats",
                 $time, cyc - last_out_cyc);
      end
      last_out_cyc = cyc;
      out_n++;
    end
  end

  task automatic apply_reset();
    i_rst_n = 1'b0;
    i_val   = 1'b0;
    repeat (4) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;
  endtask

  // Drives the table and holds each beat until the input takes it
  task automatic drive_table();
    beat_t b;
    int    idle;
    logic  took;
    for (int r = 0; r < NUM_ROWS && timeouts == 0; r++) begin
      if (stall_mode && ($urandom % 4 == 0)) begin
        idle  = int'($urandom % 3) + 1;
        i_val = 1'b0;
        repeat (idle) @(posedge i_clk);
        #1;
      end
      b      = make_beat(r);
      i_beat = b;
      i_val  = 1'b1;
      took   = 1'b0;
      for (int w = 0; w < WAIT_LIMIT && !took; w++) begin
        @(posedge i_clk);
        took = o_rdy;
      end
      if (!took) begin
        timeouts++;
        $display("Timeout: input ready stayed low for %0d cycles at row %0d",
                 WAIT_LIMIT, r);
      end else begin
        b.err = rows[r].err_exp;
        exp_q.push_back(b);
        if (r == 0) begin
          first_in_cyc = cyc;
        end
        #1;
      end
    end
    i_val = 1'b0;
  endtask

  task automatic run_test(input string name, input bit stall);
    int   err_before;
    int   exp_pkts;
    int   exp_errs;
    logic drained;
    err_before = errors;
    stall_mode = stall;
    apply_reset();
    out_n    = 0;
    exp_pkts = 0;
    exp_errs = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      exp_pkts += int'(rows[r].eop);
      exp_errs += int'(rows[r].err_exp);
    end
    drive_table();
    drained = 1'b0;
    for (int w = 0; w < WAIT_LIMIT && !drained && timeouts == 0; w++) begin
      @(posedge i_clk);
      #1;
      drained = (exp_q.size() == 0);
    end
    if (timeouts == 0 && !drained) begin
      timeouts++;
      $display("Timeout: %0d beats still missing at the output after %0d cycles",
               exp_q.size(), WAIT_LIMIT);
    end
    if (timeouts == 0) begin
      // A duplicated beat behind the last one shows up within a few cycles
      repeat (2 * LATENCY) @(posedge i_clk);
      #1;
      checks++;
      if (out_n != NUM_ROWS) begin
        errors++;
        $display("ERR %0t: %0d beats out, expected %0d", $time, out_n, NUM_ROWS);
      end
      compare_cnt(o_pkt_cnt, cnt_t'(exp_pkts), "packet count");
      compare_cnt(o_err_cnt, cnt_t'(exp_errs), "error count");
    end
    $display("test %s: %0d beats in, %0d beats out, %s", name, NUM_ROWS, out_n,
             (errors == err_before && timeouts == 0) ? "pass" : "fail");
  endtask

  initial begin
    void'($urandom(32'h2db48c70));
    i_rst_n      = 1'b0;
    i_val        = 1'b0;
    i_beat       = '0;
    stall_mode   = 1'b0;
    checks       = 0;
    errors       = 0;
    timeouts     = 0;
    out_n        = 0;
    first_in_cyc = 0;
    last_out_cyc = 0;
    load_table();
    run_test("full_rate", 1'b0);
    if (timeouts == 0) begin
      run_test("backpressure", 1'b1);
    end
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+hdl
hdl/stream_pkg.sv
hdl/pipeline_if_single.sv
hdl/pipeline_if.sv
hdl/stream_frame_check.sv
hdl/stream_pipe_top.sv
verification/stream_pipe_assert.sv
verification/stream_pipe_tb.sv

//--- Makefile
# Verilator build and run for the stream packet pipeline

SRCS = hdl/stream_params.svh \
       hdl/stream_pkg.sv \
       hdl/pipeline_if_single.sv \
       hdl/pipeline_if.sv \
       hdl/stream_frame_check.sv \
       hdl/stream_pipe_top.sv \
       verification/stream_pipe_assert.sv \
       verification/stream_pipe_tb.sv

.PHONY: all run clean

all: obj_dir/Vstream_pipe_tb

# Rebuilt only when a source or the file list changes
obj_dir/Vstream_pipe_tb: sources.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module stream_pipe_tb -f sources.f -o Vstream_pipe_tb

# The log decides the result, a crashed run has no pass line either
run: obj_dir/Vstream_pipe_tb
	-./obj_dir/Vstream_pipe_tb > sim.log 2>&1
	cat sim.log
	! grep -q "Test FAILED" sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
